//--- logic/rv_params.svh
// RV64I front end parameters.
// Datapath widths, instruction buffer depth and the boot address.

`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data and pc width.
`define RV_XLEN        64
// raw instruction width.
`define RV_ILEN        32
// register index width.
`define RV_RIDX        5
// instruction buffer entries and the initial credit count.
`define RV_FIFO_DEPTH  4
// first fetch address.
`define RV_RESET_PC    64'h0000_0000_8000_0000

`endif

//--- logic/rv_pkg.sv
// RV64I front end types.
// Shared vectors and enums for fetch, buffer and decode.

`include "rv_params.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0] xlen_t;
  typedef logic [`RV_ILEN-1:0] inst_t;
  typedef logic [`RV_RIDX-1:0] ridx_t;

  // counts 0 through the buffer depth.
  typedef logic [$clog2(`RV_FIFO_DEPTH + 1)-1:0] credit_t;

  // instruction format.
  typedef enum logic [2:0] {
    TYPE_NONE, TYPE_R, TYPE_I, TYPE_S, TYPE_B, TYPE_U, TYPE_J
  } inst_type_e;

  // operation class.
  typedef enum logic [4:0] {
    OP_ILLEGAL, OP_ALU_REG, OP_ALU_IMM, OP_ALU_REG_W, OP_ALU_IMM_W,
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE
  } inst_op_e;

  typedef enum logic {
    FETCH_IDLE,
    FETCH_WAIT_RESP
  } fetch_state_e;

endpackage

//--- logic/fetch_unit.sv
// Fetch unit.
// Steps the pc, reads instruction memory and pushes words under credit control.

`timescale 1ns/1ps
`include "rv_params.svh"

module fetch_unit
  import rv_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   i_credit_ret,
  output logic   o_imem_req,
  output xlen_t  o_imem_addr,
  input  inst_t  i_imem_rdata,
  output logic   o_push_valid,
  output xlen_t  o_push_pc,
  output inst_t  o_push_inst
);

  fetch_state_e state;
  credit_t      credit;
  xlen_t        pc;
  logic         credit_avail;

  // a credit returned this cycle is usable for the next request.
  assign credit_avail = (credit != '0) || i_credit_ret;

  assign o_imem_addr  = pc;
  assign o_push_valid = (state == FETCH_WAIT_RESP);
  assign o_push_pc    = pc;
  assign o_push_inst  = i_imem_rdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= FETCH_IDLE;
      o_imem_req <= 1'b0;
      credit     <= credit_t'(`RV_FIFO_DEPTH);
      pc         <= `RV_RESET_PC;
    end else begin
      credit <= credit - credit_t'(o_imem_req) + credit_t'(i_credit_ret);
      case (state)
        FETCH_IDLE: begin
          if (o_imem_req) begin
            o_imem_req <= 1'b0;
            state      <= FETCH_WAIT_RESP;
          end else begin
            o_imem_req <= credit_avail;
          end
        end
        FETCH_WAIT_RESP: begin
          // the word is pushed on the response cycle.
          pc         <= pc + xlen_t'(4);
          state      <= FETCH_IDLE;
          o_imem_req <= credit_avail;
        end
        default: state <= FETCH_IDLE;
      endcase
    end
  end

  // buffer must never hand back more credits than it has slots.
  a_credit_bound: assert property (@(posedge clk) disable iff (rst)
    credit <= credit_t'(`RV_FIFO_DEPTH));

endmodule

//--- logic/inst_fifo.sv
// Instruction buffer.
// Circular FIFO of pc and instruction pairs, one credit back per pop.

`timescale 1ns/1ps
`include "rv_params.svh"

module inst_fifo
  import rv_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   i_push_valid,
  input  xlen_t  i_push_pc,
  input  inst_t  i_push_inst,
  input  logic   i_pop,
  output logic   o_not_empty,
  output xlen_t  o_head_pc,
  output inst_t  o_head_inst,
  output logic   o_credit_ret
);

  localparam int               PTR_W    = $clog2(`RV_FIFO_DEPTH);
  localparam logic [PTR_W-1:0] LAST_IDX = PTR_W'(`RV_FIFO_DEPTH - 1);
  localparam credit_t          FULL_CNT = credit_t'(`RV_FIFO_DEPTH);

  xlen_t            pc_mem   [`RV_FIFO_DEPTH];
  inst_t            inst_mem [`RV_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  credit_t          count;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_IDX) ? '0 : ptr + 1'b1;
  endfunction

  assign o_not_empty  = (count != '0);
  assign o_head_pc    = pc_mem[rd_ptr];
  assign o_head_inst  = inst_mem[rd_ptr];
  assign o_credit_ret = i_pop;

  always_ff @(posedge clk) begin
    if (i_push_valid) begin
      pc_mem[wr_ptr]   <= i_push_pc;
      inst_mem[wr_ptr] <= i_push_inst;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push_valid) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (i_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count <= count + credit_t'(i_push_valid) - credit_t'(i_pop);
    end
  end

  // ---------------------------------------------------------------------------
  // the credit loop in fetch keeps pushes off a full buffer.
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    i_push_valid |-> count != FULL_CNT);

  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    i_pop |-> count != '0);

endmodule

//--- logic/inst_decoder.sv
// RV64I instruction decoder.
// Classifies the opcode, builds the immediate and selects the operands.

`timescale 1ns/1ps
`include "rv_params.svh"

module inst_decoder
  import rv_pkg::*;
(
  input  logic        i_ena,
  input  inst_t       i_inst,
  input  xlen_t       i_pc,
  input  xlen_t       i_rs1_data,
  input  xlen_t       i_rs2_data,
  output inst_type_e  o_inst_type,
  output inst_op_e    o_inst_op,
  output logic        o_rs1_ren,
  output ridx_t       o_rs1,
  output logic        o_rs2_ren,
  output ridx_t       o_rs2,
  output ridx_t       o_rd,
  output logic        o_rd_wen,
  output xlen_t       o_op1,
  output xlen_t       o_op2,
  output xlen_t       o_op3
);

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_IMM_W  = 7'b0011011;
  localparam logic [6:0] OPC_REG    = 7'b0110011;
  localparam logic [6:0] OPC_REG_W  = 7'b0111011;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       f7_base;
  logic       f7_alt;
  logic       f3_alt_ok;
  logic       imm_ok;
  logic       imm_w_ok;
  logic       reg_w_ok;
  xlen_t      imm;

  assign opcode    = i_inst[6:0];
  assign funct3    = i_inst[14:12];
  assign funct7    = i_inst[31:25];
  assign f7_base   = (funct7 == 7'b0000000);
  assign f7_alt    = (funct7 == 7'b0100000);
  // sub/sra and their word forms.
  assign f3_alt_ok = (funct3 == 3'b000) || (funct3 == 3'b101);

  // 64-bit shifts use a 6-bit shamt.
  assign imm_ok   = (funct3 == 3'b001) ? (i_inst[31:26] == 6'b000000) :
                    (funct3 == 3'b101) ? (i_inst[31:26] == 6'b000000 ||
                                          i_inst[31:26] == 6'b010000) : 1'b1;
  assign imm_w_ok = (funct3 == 3'b000) || (funct3 == 3'b001 && f7_base) ||
                    (funct3 == 3'b101 && (f7_base || f7_alt));
  assign reg_w_ok = (funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101) &&
                    (f7_base || (f7_alt && f3_alt_ok));

  // ---------------------------------------------------------------------------
  // operation class.
  always_comb begin
    o_inst_op = OP_ILLEGAL;
    if (i_ena) begin
      case (opcode)
        OPC_LUI:    o_inst_op = OP_LUI;
        OPC_AUIPC:  o_inst_op = OP_AUIPC;
        OPC_JAL:    o_inst_op = OP_JAL;
        OPC_JALR:   o_inst_op = (funct3 == 3'b000) ? OP_JALR : OP_ILLEGAL;
        OPC_BRANCH: o_inst_op = (funct3[2:1] != 2'b01) ? OP_BRANCH : OP_ILLEGAL;
        OPC_LOAD:   o_inst_op = (funct3 != 3'b111) ? OP_LOAD : OP_ILLEGAL;
        OPC_STORE:  o_inst_op = (funct3[2] == 1'b0) ? OP_STORE : OP_ILLEGAL;
        OPC_IMM:    o_inst_op = imm_ok ? OP_ALU_IMM : OP_ILLEGAL;
        OPC_IMM_W:  o_inst_op = imm_w_ok ? OP_ALU_IMM_W : OP_ILLEGAL;
        OPC_REG:    o_inst_op = (f7_base || (f7_alt && f3_alt_ok)) ? OP_ALU_REG : OP_ILLEGAL;
        OPC_REG_W:  o_inst_op = reg_w_ok ? OP_ALU_REG_W : OP_ILLEGAL;
        default:    o_inst_op = OP_ILLEGAL;
      endcase
    end
  end

  // format and register usage follow from the class.
  always_comb begin
    case (o_inst_op)
      OP_ALU_REG, OP_ALU_REG_W:        o_inst_type = TYPE_R;
      OP_ALU_IMM, OP_ALU_IMM_W,
      OP_JALR, OP_LOAD:                o_inst_type = TYPE_I;
      OP_STORE:                        o_inst_type = TYPE_S;
      OP_BRANCH:                       o_inst_type = TYPE_B;
      OP_LUI, OP_AUIPC:                o_inst_type = TYPE_U;
      OP_JAL:                          o_inst_type = TYPE_J;
      default:                         o_inst_type = TYPE_NONE;
    endcase
  end

  assign o_rs1_ren = !(o_inst_op inside {OP_ILLEGAL, OP_LUI, OP_AUIPC, OP_JAL});
  assign o_rs2_ren = (o_inst_type inside {TYPE_R, TYPE_S, TYPE_B});
  assign o_rd_wen  = !(o_inst_type inside {TYPE_NONE, TYPE_S, TYPE_B});

  assign o_rs1 = o_rs1_ren ? i_inst[19:15] : '0;
  assign o_rs2 = o_rs2_ren ? i_inst[24:20] : '0;
  assign o_rd  = o_rd_wen ? i_inst[11:7] : '0;

  // ---------------------------------------------------------------------------
  // sign-extended immediate.
  always_comb begin
    case (o_inst_type)
      TYPE_I:  imm = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:20]};
      TYPE_S:  imm = {{(`RV_XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      TYPE_B:  imm = {{(`RV_XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7],
                      i_inst[30:25], i_inst[11:8], 1'b0};
      TYPE_U:  imm = {{(`RV_XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
      TYPE_J:  imm = {{(`RV_XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12],
                      i_inst[20], i_inst[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

  always_comb begin
    case (o_inst_op)
      OP_ILLEGAL, OP_LUI: o_op1 = '0;
      OP_AUIPC, OP_JAL:   o_op1 = i_pc;
      default:            o_op1 = i_rs1_data;
    endcase
  end

  assign o_op2 = o_rs2_ren ? i_rs2_data : imm;

  always_comb begin
    case (o_inst_op)
      OP_STORE, OP_BRANCH: o_op3 = imm;
      OP_JAL, OP_JALR:     o_op3 = i_pc + xlen_t'(4);
      default:             o_op3 = '0;
    endcase
  end

endmodule

//--- logic/id_stage.sv
// Instruction decode stage.
// Holds one popped word and offers its decode on a valid/ack handshake.

`timescale 1ns/1ps

module id_stage
  import rv_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        i_not_empty,
  input  xlen_t       i_head_pc,
  input  inst_t       i_head_inst,
  output logic        o_pop,
  input  xlen_t       i_rs1_data,
  input  xlen_t       i_rs2_data,
  output ridx_t       o_rs1,
  output ridx_t       o_rs2,
  input  logic        i_dec_ack,
  output logic        o_dec_valid,
  output xlen_t       o_dec_pc,
  output inst_t       o_dec_inst,
  output logic        o_rs1_ren,
  output logic        o_rs2_ren,
  output ridx_t       o_rd,
  output logic        o_rd_wen,
  output inst_type_e  o_inst_type,
  output inst_op_e    o_inst_op,
  output xlen_t       o_op1,
  output xlen_t       o_op2,
  output xlen_t       o_op3
);

  logic  held;
  logic  transfer;
  xlen_t pc_q;
  inst_t inst_q;

  assign transfer = held && i_dec_ack;

  // refill when empty or while the held word leaves.
  assign o_pop = i_not_empty && (!held || transfer);

  assign o_dec_valid = held;
  assign o_dec_pc    = held ? pc_q : '0;
  assign o_dec_inst  = held ? inst_q : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      held <= 1'b0;
    end else if (o_pop) begin
      held <= 1'b1;
    end else if (transfer) begin
      held <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (o_pop) begin
      pc_q   <= i_head_pc;
      inst_q <= i_head_inst;
    end
  end

  inst_decoder u_dec (
    .i_ena       (held),
    .i_inst      (inst_q),
    .i_pc        (pc_q),
    .i_rs1_data  (i_rs1_data),
    .i_rs2_data  (i_rs2_data),
    .o_inst_type (o_inst_type),
    .o_inst_op   (o_inst_op),
    .o_rs1_ren   (o_rs1_ren),
    .o_rs1       (o_rs1),
    .o_rs2_ren   (o_rs2_ren),
    .o_rs2       (o_rs2),
    .o_rd        (o_rd),
    .o_rd_wen    (o_rd_wen),
    .o_op1       (o_op1),
    .o_op2       (o_op2),
    .o_op3       (o_op3)
  );

  // op1 and op2 follow the register file, so they are left out here.
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    o_dec_valid && !i_dec_ack |=> o_dec_valid && $stable(o_dec_pc) &&
    $stable(o_dec_inst) && $stable(o_inst_op) && $stable(o_rd) && $stable(o_op3));

endmodule

//--- logic/regfile.sv
// Integer register file.
// Two asynchronous read ports, one write port, x0 reads as zero.

`timescale 1ns/1ps
`include "rv_params.svh"

module regfile
  import rv_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  ridx_t  i_raddr1,
  input  ridx_t  i_raddr2,
  output xlen_t  o_rdata1,
  output xlen_t  o_rdata2,
  input  logic   i_wen,
  input  ridx_t  i_waddr,
  input  xlen_t  i_wdata
);

  localparam int NREGS = 2 ** `RV_RIDX;

  xlen_t regs [NREGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // x0 is hard-wired.
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

//--- logic/decode_top.sv
// Front end top level.
// Fetch, instruction buffer, decode stage and register file.

`timescale 1ns/1ps

module decode_top
  import rv_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  output logic        o_imem_req,
  output xlen_t       o_imem_addr,
  input  inst_t       i_imem_rdata,
  input  logic        i_wb_en,
  input  ridx_t       i_wb_rd,
  input  xlen_t       i_wb_data,
  input  logic        i_dec_ack,
  output logic        o_dec_valid,
  output xlen_t       o_dec_pc,
  output inst_t       o_dec_inst,
  output logic        o_rs1_ren,
  output ridx_t       o_rs1,
  output logic        o_rs2_ren,
  output ridx_t       o_rs2,
  output ridx_t       o_rd,
  output logic        o_rd_wen,
  output inst_type_e  o_inst_type,
  output inst_op_e    o_inst_op,
  output xlen_t       o_op1,
  output xlen_t       o_op2,
  output xlen_t       o_op3
);

  logic  push_valid;
  xlen_t push_pc;
  inst_t push_inst;
  logic  credit_ret;
  logic  pop;
  logic  not_empty;
  xlen_t head_pc;
  inst_t head_inst;
  xlen_t rs1_data;
  xlen_t rs2_data;

  fetch_unit u_fetch (
    .clk          (clk),
    .rst          (rst),
    .i_credit_ret (credit_ret),
    .o_imem_req   (o_imem_req),
    .o_imem_addr  (o_imem_addr),
    .i_imem_rdata (i_imem_rdata),
    .o_push_valid (push_valid),
    .o_push_pc    (push_pc),
    .o_push_inst  (push_inst)
  );

  inst_fifo u_fifo (
    .clk          (clk),
    .rst          (rst),
    .i_push_valid (push_valid),
    .i_push_pc    (push_pc),
    .i_push_inst  (push_inst),
    .i_pop        (pop),
    .o_not_empty  (not_empty),
    .o_head_pc    (head_pc),
    .o_head_inst  (head_inst),
    .o_credit_ret (credit_ret)
  );

  id_stage u_id (
    .clk         (clk),
    .rst         (rst),
    .i_not_empty (not_empty),
    .i_head_pc   (head_pc),
    .i_head_inst (head_inst),
    .o_pop       (pop),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .o_rs1       (o_rs1),
    .o_rs2       (o_rs2),
    .i_dec_ack   (i_dec_ack),
    .o_dec_valid (o_dec_valid),
    .o_dec_pc    (o_dec_pc),
    .o_dec_inst  (o_dec_inst),
    .o_rs1_ren   (o_rs1_ren),
    .o_rs2_ren   (o_rs2_ren),
    .o_rd        (o_rd),
    .o_rd_wen    (o_rd_wen),
    .o_inst_type (o_inst_type),
    .o_inst_op   (o_inst_op),
    .o_op1       (o_op1),
    .o_op2       (o_op2),
    .o_op3       (o_op3)
  );

  // read addresses come from the held instruction.
  regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .i_raddr1 (o_rs1),
    .i_raddr2 (o_rs2),
    .o_rdata1 (rs1_data),
    .o_rdata2 (rs2_data),
    .i_wen    (i_wb_en),
    .i_waddr  (i_wb_rd),
    .i_wdata  (i_wb_data)
  );

endmodule

//--- bench/tb_clock_gen.sv
// Testbench clock and reset.
// 8 ns clock, reset held for 5 cycles at start and on each restart request.

`timescale 1ns/1ps

module tb_clock_gen (
  input  logic i_restart,
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    forever begin
      @(posedge i_restart);
      rst <= 1'b1;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
    end
  end

endmodule

//--- bench/decode_tb.sv
// Front end testbench.
// Instruction memory model, directed decode tests and the closing report.

`timescale 1ns/1ps
`include "rv_params.svh"

module decode_tb
  import rv_pkg::*;
();

  localparam int MEM_WORDS  = 32;
  localparam int WAIT_LIMIT = 100;
  localparam int BOUND      = `RV_FIFO_DEPTH + 2;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_IMM_W  = 7'b0011011;
  localparam logic [6:0] OPC_REG    = 7'b0110011;
  localparam logic [6:0] OPC_REG_W  = 7'b0111011;

  logic       clk;
  logic       rst;
  logic       restart;
  logic       imem_req;
  xlen_t      imem_addr;
  inst_t      imem_rdata;
  logic       wb_en;
  ridx_t      wb_rd;
  xlen_t      wb_data;
  logic       dec_ack;
  logic       dec_valid;
  xlen_t      dec_pc;
  inst_t      dec_inst;
  logic       rs1_ren;
  ridx_t      rs1;
  logic       rs2_ren;
  ridx_t      rs2;
  ridx_t      rd;
  logic       rd_wen;
  inst_type_e inst_type;
  inst_op_e   inst_op;
  xlen_t      op1;
  xlen_t      op2;
  xlen_t      op3;

  inst_t mem [MEM_WORDS];
  inst_t prog [$];
  xlen_t shadow [32];
  xlen_t exp_pc;
  int    seed = 38;
  int    mismatch_errs;
  int    other_errs;
  bit    aborted;
  int    req_cnt;
  int    xfer_cnt;

  tb_clock_gen u_clock_gen (
    .i_restart (restart),
    .clk       (clk),
    .rst       (rst)
  );

  decode_top u_decode_top (
    .clk          (clk),
    .rst          (rst),
    .o_imem_req   (imem_req),
    .o_imem_addr  (imem_addr),
    .i_imem_rdata (imem_rdata),
    .i_wb_en      (wb_en),
    .i_wb_rd      (wb_rd),
    .i_wb_data    (wb_data),
    .i_dec_ack    (dec_ack),
    .o_dec_valid  (dec_valid),
    .o_dec_pc     (dec_pc),
    .o_dec_inst   (dec_inst),
    .o_rs1_ren    (rs1_ren),
    .o_rs1        (rs1),
    .o_rs2_ren    (rs2_ren),
    .o_rs2        (rs2),
    .o_rd         (rd),
    .o_rd_wen     (rd_wen),
    .o_inst_type  (inst_type),
    .o_inst_op    (inst_op),
    .o_op1        (op1),
    .o_op2        (op2),
    .o_op3        (op3)
  );

  // ---------------------------------------------------------------------------
  // instruction memory model answering one cycle after each request.
  function automatic inst_t fill_word(input xlen_t addr);
    return addr[63:32] ^ addr[31:0] ^ 32'h5a5a_0000;
  endfunction

  function automatic inst_t fetch_word(input xlen_t addr);
    xlen_t off;
    off = addr - xlen_t'(`RV_RESET_PC);
    if (off < xlen_t'(MEM_WORDS * 4)) begin
      return mem[off >> 2];
    end
    return fill_word(addr);
  endfunction

  always @(negedge clk) begin
    if (imem_req) begin
      imem_rdata <= fetch_word(imem_addr);
    end
  end

  // requests not yet transferred.
  always @(posedge clk) begin
    if (rst) begin
      req_cnt  = 0;
      xfer_cnt = 0;
    end else begin
      if (imem_req) req_cnt++;
      if (dec_valid && dec_ack) xfer_cnt++;
      if (req_cnt - xfer_cnt > BOUND) begin
        other_errs++;
        $display("Error: %0d words in flight, more than %0d", req_cnt - xfer_cnt, BOUND);
      end
    end
  end

  // ---------------------------------------------------------------------------
  // encoders and immediate helpers.
  function automatic inst_t enc_r(input logic [6:0] f7, input logic [4:0] s2,
                                  input logic [4:0] s1, input logic [2:0] f3,
                                  input logic [4:0] d, input logic [6:0] opc);
    return {f7, s2, s1, f3, d, opc};
  endfunction

  function automatic inst_t enc_i(input logic [31:0] imm, input logic [4:0] s1,
                                  input logic [2:0] f3, input logic [4:0] d,
                                  input logic [6:0] opc);
    return {imm[11:0], s1, f3, d, opc};
  endfunction

  function automatic inst_t enc_s(input logic [31:0] imm, input logic [4:0] s2,
                                  input logic [4:0] s1, input logic [2:0] f3,
                                  input logic [6:0] opc);
    return {imm[11:5], s2, s1, f3, imm[4:0], opc};
  endfunction

  function automatic inst_t enc_b(input logic [31:0] imm, input logic [4:0] s2,
                                  input logic [4:0] s1, input logic [2:0] f3);
    return {imm[12], imm[10:5], s2, s1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic inst_t enc_u(input logic [31:0] val, input logic [4:0] d,
                                  input logic [6:0] opc);
    return {val[31:12], d, opc};
  endfunction

  function automatic inst_t enc_j(input logic [31:0] imm, input logic [4:0] d);
    return {imm[20], imm[10:1], imm[11], imm[19:12], d, OPC_JAL};
  endfunction

  function automatic xlen_t sext(input logic [31:0] v, input int w);
    xlen_t mask;
    xlen_t x;
    mask = (xlen_t'(1) << w) - xlen_t'(1);
    x    = xlen_t'(v) & mask;
    if (x[w-1]) x = x | ~mask;
    return x;
  endfunction

  // ---------------------------------------------------------------------------
  task automatic compare_xlen(input string name, input string field,
                              input xlen_t exp, input xlen_t act);
    if (exp !== act) begin
      mismatch_errs++;
      $display("Mismatch %s %s: expected %h actual %h", name, field, exp, act);
    end
  endtask

  task automatic compare_inst(input string name, input inst_t exp, input inst_t act);
    if (exp !== act) begin
      mismatch_errs++;
      $display("Mismatch %s inst: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic compare_ridx(input string name, input string field,
                              input ridx_t exp, input ridx_t act);
    if (exp !== act) begin
      mismatch_errs++;
      $display("Mismatch %s %s: expected %0d actual %0d", name, field, exp, act);
    end
  endtask

  task automatic compare_bit(input string name, input string field,
                             input logic exp, input logic act);
    if (exp !== act) begin
      mismatch_errs++;
      $display("Mismatch %s %s: expected %b actual %b", name, field, exp, act);
    end
  endtask

  task automatic compare_type(input string name, input inst_type_e exp,
                              input inst_type_e act);
    if (exp !== act) begin
      mismatch_errs++;
      $display("Mismatch %s type: expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic compare_op(input string name, input inst_op_e exp, input inst_op_e act);
    if (exp !== act) begin
      mismatch_errs++;
      $display("Mismatch %s op: expected %s actual %s", name, exp.name(), act.name());
    end
  endtask

  // ---------------------------------------------------------------------------
  task automatic wait_reset_release(input string name);
    int n;
    n = 0;
    while (rst && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (rst) begin
      other_errs++;
      aborted = 1'b1;
      $display("Error: %s reset was never released", name);
    end
  endtask

  task automatic wait_valid(input string name);
    int n;
    n = 0;
    while (!dec_valid && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!dec_valid) begin
      other_errs++;
      aborted = 1'b1;
      $display("Error: %s timed out waiting for a decoded instruction", name);
    end
  endtask

  // reset the front end and load the program while it is held.
  task automatic start_test(input string name);
    if (aborted) return;
    @(negedge clk);
    wait_reset_release(name);
    if (aborted) return;
    restart = 1'b1;
    @(negedge clk);
    restart = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(xlen_t'(`RV_RESET_PC) + xlen_t'(i * 4));
    end
    foreach (prog[i]) mem[i] = prog[i];
    for (int i = 0; i < 32; i++) shadow[i] = '0;
    exp_pc = `RV_RESET_PC;
    wait_reset_release(name);
  endtask

  task automatic write_reg(input ridx_t idx, input xlen_t data);
    wb_en   = 1'b1;
    wb_rd   = idx;
    wb_data = data;
    @(negedge clk);
    wb_en = 1'b0;
    if (idx != '0) shadow[idx] = data;
  endtask

  task automatic random_regs(input int n);
    for (int i = 1; i <= n; i++) begin
      write_reg(ridx_t'(i), {$random(seed), $random(seed)});
    end
  endtask

  // en is {rs1_ren, rs2_ren, rd_wen}.
  task automatic check_decode(input string name, input inst_t inst,
                              input inst_type_e exp_type, input inst_op_e exp_op,
                              input logic [2:0] en, input xlen_t e1, input xlen_t e2,
                              input xlen_t e3, input int hold);
    if (aborted) return;
    wait_valid(name);
    if (aborted) return;
    compare_xlen(name, "pc", exp_pc, dec_pc);
    compare_inst(name, inst, dec_inst);
    compare_type(name, exp_type, inst_type);
    compare_op(name, exp_op, inst_op);
    compare_bit(name, "rs1_ren", en[2], rs1_ren);
    compare_bit(name, "rs2_ren", en[1], rs2_ren);
    compare_bit(name, "rd_wen", en[0], rd_wen);
    if (en[2]) compare_ridx(name, "rs1", inst[19:15], rs1);
    if (en[1]) compare_ridx(name, "rs2", inst[24:20], rs2);
    if (en[0]) compare_ridx(name, "rd", inst[11:7], rd);
    if (exp_op != OP_ILLEGAL) begin
      compare_xlen(name, "op1", e1, op1);
      compare_xlen(name, "op2", e2, op2);
      compare_xlen(name, "op3", e3, op3);
    end
    // outputs must hold while the consumer stalls.
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      if (!dec_valid) begin
        other_errs++;
        $display("Error: %s valid dropped while waiting for ack", name);
      end
      compare_xlen({name, " held"}, "pc", exp_pc, dec_pc);
      compare_inst({name, " held"}, inst, dec_inst);
      compare_type({name, " held"}, exp_type, inst_type);
      compare_op({name, " held"}, exp_op, inst_op);
      if (en[0]) compare_ridx({name, " held"}, "rd", inst[11:7], rd);
      if (exp_op != OP_ILLEGAL) begin
        compare_xlen({name, " held"}, "op1", e1, op1);
        compare_xlen({name, " held"}, "op2", e2, op2);
        compare_xlen({name, " held"}, "op3", e3, op3);
      end
    end
    dec_ack = 1'b1;
    @(negedge clk);
    dec_ack = 1'b0;
    exp_pc = exp_pc + xlen_t'(4);
  endtask

  // ---------------------------------------------------------------------------
  task automatic run_rtype();
    inst_t w [4];
    w[0] = enc_r(7'h00, 2, 1, 3'd0, 5, OPC_REG);
    w[1] = enc_r(7'h20, 4, 3, 3'd0, 6, OPC_REG);
    w[2] = enc_r(7'h00, 3, 1, 3'd0, 7, OPC_REG_W);
    w[3] = enc_r(7'h20, 4, 2, 3'd5, 8, OPC_REG_W);
    prog.delete();
    foreach (w[i]) prog.push_back(w[i]);
    start_test("rtype");
    random_regs(4);
    check_decode("rtype add", w[0], TYPE_R, OP_ALU_REG, 3'b111, shadow[1], shadow[2], 0, 0);
    check_decode("rtype sub", w[1], TYPE_R, OP_ALU_REG, 3'b111, shadow[3], shadow[4], 0, 0);
    check_decode("rtype addw", w[2], TYPE_R, OP_ALU_REG_W, 3'b111, shadow[1], shadow[3], 0, 0);
    check_decode("rtype sraw", w[3], TYPE_R, OP_ALU_REG_W, 3'b111, shadow[2], shadow[4], 0, 0);
  endtask

  task automatic run_immediates();
    inst_t w [9];
    w[0] = enc_i(-5, 1, 3'd0, 9, OPC_IMM);
    w[1] = enc_i(32'h7f8, 2, 3'd3, 10, OPC_LOAD);
    w[2] = enc_s(-16, 3, 4, 3'd3, OPC_STORE);
    w[3] = enc_b(-8, 2, 1, 3'd0);
    w[4] = enc_u(32'h8000_1000, 11, OPC_LUI);
    w[5] = enc_u(32'h1234_5000, 12, OPC_AUIPC);
    w[6] = enc_j(-2048, 1);
    w[7] = enc_i(12, 5, 3'd0, 13, OPC_JALR);
    w[8] = enc_i(32'h7ff, 2, 3'd0, 14, OPC_IMM_W);
    prog.delete();
    foreach (w[i]) prog.push_back(w[i]);
    start_test("imm");
    random_regs(5);
    check_decode("imm addi", w[0], TYPE_I, OP_ALU_IMM, 3'b101, shadow[1], sext(-5, 12), 0, 0);
    check_decode("imm ld", w[1], TYPE_I, OP_LOAD, 3'b101, shadow[2], sext(32'h7f8, 12), 0, 0);
    check_decode("imm sd", w[2], TYPE_S, OP_STORE, 3'b110, shadow[4], shadow[3],
                 sext(-16, 12), 0);
    check_decode("imm beq", w[3], TYPE_B, OP_BRANCH, 3'b110, shadow[1], shadow[2],
                 sext(-8, 13), 0);
    check_decode("imm lui", w[4], TYPE_U, OP_LUI, 3'b001, 0, sext(32'h8000_1000, 32), 0, 0);
    check_decode("imm auipc", w[5], TYPE_U, OP_AUIPC, 3'b001, exp_pc,
                 sext(32'h1234_5000, 32), 0, 0);
    check_decode("imm jal", w[6], TYPE_J, OP_JAL, 3'b001, exp_pc, sext(-2048, 21),
                 exp_pc + xlen_t'(4), 0);
    check_decode("imm jalr", w[7], TYPE_I, OP_JALR, 3'b101, shadow[5], sext(12, 12),
                 exp_pc + xlen_t'(4), 0);
    check_decode("imm addiw", w[8], TYPE_I, OP_ALU_IMM_W, 3'b101, shadow[2],
                 sext(32'h7ff, 12), 0, 0);
  endtask

  task automatic run_zero_reg();
    inst_t w [4];
    w[0] = enc_r(7'h00, 0, 0, 3'd0, 5, OPC_REG);
    w[1] = enc_r(7'h20, 1, 0, 3'd0, 6, OPC_REG);
    w[2] = enc_i(-1, 0, 3'd0, 7, OPC_IMM);
    w[3] = enc_s(8, 0, 1, 3'd3, OPC_STORE);
    prog.delete();
    foreach (w[i]) prog.push_back(w[i]);
    start_test("x0");
    write_reg(0, {$random(seed), $random(seed)});
    write_reg(1, {$random(seed), $random(seed)});
    check_decode("x0 add", w[0], TYPE_R, OP_ALU_REG, 3'b111, 0, 0, 0, 0);
    check_decode("x0 sub", w[1], TYPE_R, OP_ALU_REG, 3'b111, 0, shadow[1], 0, 0);
    check_decode("x0 addi", w[2], TYPE_I, OP_ALU_IMM, 3'b101, 0, sext(-1, 12), 0, 0);
    check_decode("x0 sd", w[3], TYPE_S, OP_STORE, 3'b110, shadow[1], 0, sext(8, 12), 0);
  endtask

  task automatic run_illegal();
    inst_t w [6];
    w[0] = 32'h0000_0000;
    w[1] = 32'hffff_ffff;
    // csrrw uses the system opcode.
    w[2] = 32'h3052_9073;
    // mul from the M extension.
    w[3] = enc_r(7'h01, 3, 2, 3'd0, 1, OPC_REG);
    w[4] = enc_i(1, 1, 3'd0, 5, OPC_IMM);
    w[5] = enc_r(7'h00, 2, 1, 3'd7, 9, OPC_REG);
    prog.delete();
    foreach (w[i]) prog.push_back(w[i]);
    start_test("illegal");
    random_regs(2);
    check_decode("illegal zero", w[0], TYPE_NONE, OP_ILLEGAL, 3'b000, 0, 0, 0, 0);
    check_decode("illegal ones", w[1], TYPE_NONE, OP_ILLEGAL, 3'b000, 0, 0, 0, 0);
    check_decode("illegal csr", w[2], TYPE_NONE, OP_ILLEGAL, 3'b000, 0, 0, 0, 0);
    check_decode("illegal mul", w[3], TYPE_NONE, OP_ILLEGAL, 3'b000, 0, 0, 0, 0);
    check_decode("illegal addi", w[4], TYPE_I, OP_ALU_IMM, 3'b101, shadow[1], 1, 0, 0);
    check_decode("illegal and", w[5], TYPE_R, OP_ALU_REG, 3'b111, shadow[1], shadow[2], 0, 0);
  endtask

  task automatic run_backpressure();
    string nm;
    int    imm;
    prog.delete();
    for (int i = 0; i < 12; i++) begin
      prog.push_back(enc_i(i * 100 - 500, 0, 3'd0, i + 1, OPC_IMM));
    end
    start_test("order");
    for (int i = 0; i < 12; i++) begin
      nm  = $sformatf("order %0d", i);
      imm = i * 100 - 500;
      check_decode(nm, prog[i], TYPE_I, OP_ALU_IMM, 3'b101, 0, sext(imm, 12), 0,
                   {$random(seed)} % 6);
    end
  endtask

  initial begin
    restart       = 1'b0;
    wb_en         = 1'b0;
    wb_rd         = '0;
    wb_data       = '0;
    dec_ack       = 1'b0;
    imem_rdata    = '0;
    mismatch_errs = 0;
    other_errs    = 0;
    aborted       = 1'b0;
    run_rtype();
    run_immediates();
    run_zero_reg();
    run_illegal();
    run_backpressure();
    $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+logic
logic/rv_pkg.sv
logic/fetch_unit.sv
logic/inst_fifo.sv
logic/inst_decoder.sv
logic/id_stage.sv
logic/regfile.sv
logic/decode_top.sv
bench/tb_clock_gen.sv
bench/decode_tb.sv
